//--- conv1_pkg.sv
package conv1_pkg;

	// ====================================================================
	// Data path sizes
	// ====================================================================
	localparam int DATA_WIDTH = 16;                  // Activations, weights, results.
	localparam int ACC_WIDTH = 40;                   // Lane accumulator.
	localparam int KERNEL = 3;                       // Kernel side.
	localparam int CHANNELS = 3;                     // Input channels.
	localparam int PATCH_LEN = KERNEL * KERNEL * CHANNELS;
	localparam int ADDR_WIDTH = 5;                   // Kernel position, 32 ROM rows.
	localparam int NUM_FILTERS = 8;                  // One lane per filter.
	localparam int FILTER_IDX_WIDTH = 3;

	// ====================================================================
	// Fixed point
	// ====================================================================
	localparam int FRAC_BITS = 8;                    // Output scaling shift.
	localparam int SAT_MAX = 32767;                  // Largest 16-bit result.

	localparam string WEIGHT_FILE = "weights.mem";

	// ====================================================================
	// FSM states
	// ====================================================================
	typedef enum logic [1:0] {
		IDLE,
		WAIT_REQ,
		ACK_HIGH,
		WAIT_DRAIN
	} loader_state_t;

	typedef enum logic [1:0] {
		EMPTY,
		SEND_REQ,
		WAIT_ACK_LOW
	} drain_state_t;

endpackage

//--- design/conv1_weight_rom.sv
`timescale 1ns/1ps

module conv1_weight_rom (
	input  logic        [conv1_pkg::ADDR_WIDTH-1:0] addr,
	output logic signed [conv1_pkg::DATA_WIDTH-1:0] weights [conv1_pkg::NUM_FILTERS]
);

	import conv1_pkg::*;

	localparam int ROW_WIDTH = NUM_FILTERS * DATA_WIDTH;
	localparam int ROWS = 2 ** ADDR_WIDTH;

	// One row per kernel position, filter 0 in the low word.
	logic [ROW_WIDTH-1:0] rom [ROWS];
	logic [ROW_WIDTH-1:0] row;

	initial begin
		$readmemh(WEIGHT_FILE, rom);
	end

	assign row = rom[addr];                        // Asynchronous read.

	// Split the row into per-lane words.
	always_comb begin
		for (int f = 0; f < NUM_FILTERS; f++) begin
			weights[f] = $signed(row[f*DATA_WIDTH +: DATA_WIDTH]);
		end
	end

endmodule

//--- design/patch_loader.sv
`timescale 1ns/1ps

module patch_loader (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    in_req,
	input  logic signed [conv1_pkg::DATA_WIDTH-1:0] in_data,
	output logic                                    in_ack,
	input  logic                                    drain_free,
	output logic                                    mac_en,
	output logic                                    first,
	output logic signed [conv1_pkg::DATA_WIDTH-1:0] act,
	output logic        [conv1_pkg::ADDR_WIDTH-1:0] addr,
	output logic                                    patch_done
);

	import conv1_pkg::*;

	loader_state_t state;
	logic [ADDR_WIDTH-1:0] count;
	logic last;
	logic accept;

	assign last = (count == ADDR_WIDTH'(PATCH_LEN - 1));
	assign addr = count;                           // Held through the mac_en cycle.

	// The last activation of a patch waits for the drain to empty.
	always_comb begin
		accept = 1'b0;
		case (state)
			IDLE, WAIT_REQ: accept = in_req && (!last || drain_free);
			WAIT_DRAIN:     accept = drain_free;
			default:        accept = 1'b0;
		endcase
	end

	// ====================================================================
	// Handshake FSM and kernel position counter
	// ====================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			count <= '0;
			in_ack <= 1'b0;
		end else begin
			case (state)
				IDLE, WAIT_REQ: begin
					if (accept) begin
						in_ack <= 1'b1;
						state <= ACK_HIGH;
					end else if (in_req) begin
						state <= WAIT_DRAIN;   // Back-pressure from the drain.
					end
				end
				WAIT_DRAIN: begin
					if (accept) begin
						in_ack <= 1'b1;
						state <= ACK_HIGH;
					end
				end
				ACK_HIGH: begin
					if (!in_req) begin
						in_ack <= 1'b0;
						if (last) begin
							count <= '0;
							state <= IDLE;     // Patch complete.
						end else begin
							count <= count + 1'b1;
							state <= WAIT_REQ;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Strobes to the lanes and the drain.
	always_ff @(posedge clk) begin
		if (reset) begin
			mac_en <= 1'b0;
			first <= 1'b0;
			patch_done <= 1'b0;
		end else begin
			mac_en <= accept;
			first <= accept && (count == '0);
			patch_done <= mac_en && last;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			act <= in_data;                        // Stable while in_req is high.
		end
	end

	ack_follows_req: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) |-> $past(in_req));

endmodule

//--- design/mac_lane.sv
`timescale 1ns/1ps

module mac_lane (
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    mac_en,
	input  logic                                    first,
	input  logic signed [conv1_pkg::DATA_WIDTH-1:0] act,
	input  logic signed [conv1_pkg::DATA_WIDTH-1:0] weight,
	output logic signed [conv1_pkg::ACC_WIDTH-1:0]  acc
);

	import conv1_pkg::*;

	localparam int PROD_WIDTH = 2 * DATA_WIDTH;

	logic signed [PROD_WIDTH-1:0] product;
	logic signed [ACC_WIDTH-1:0] product_ext;

	assign product = act * weight;
	assign product_ext = ACC_WIDTH'(product);      // Sign extended.

	always_ff @(posedge clk) begin
		if (reset) begin
			acc <= '0;
		end else if (mac_en) begin
			if (first) begin
				acc <= product_ext;                // Kernel position 0 restarts the sum.
			end else begin
				acc <= acc + product_ext;
			end
		end
	end

	// The loader only marks position 0 together with its strobe.
	first_with_strobe: assert property (@(posedge clk) disable iff (reset)
		first |-> mac_en);

endmodule

//--- design/result_drain.sv
`timescale 1ns/1ps

module result_drain (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          patch_done,
	input  logic signed [conv1_pkg::ACC_WIDTH-1:0]        acc [conv1_pkg::NUM_FILTERS],
	output logic                                          drain_free,
	output logic                                          out_req,
	output logic signed [conv1_pkg::DATA_WIDTH-1:0]       out_data,
	output logic        [conv1_pkg::FILTER_IDX_WIDTH-1:0] out_filter,
	input  logic                                          out_ack
);

	import conv1_pkg::*;

	drain_state_t state;
	logic signed [ACC_WIDTH-1:0] sums [NUM_FILTERS];
	logic last_filter;

	// Scale down, clamp negatives to zero, saturate at the 16-bit maximum.
	function automatic logic signed [DATA_WIDTH-1:0] scale_relu(
		input logic signed [ACC_WIDTH-1:0] sum
	);
		logic signed [ACC_WIDTH-1:0] shifted;
		shifted = sum >>> FRAC_BITS;
		if (shifted < 0) begin
			return '0;
		end else if (shifted > ACC_WIDTH'(SAT_MAX)) begin
			return DATA_WIDTH'(SAT_MAX);
		end else begin
			return shifted[DATA_WIDTH-1:0];
		end
	endfunction

	assign last_filter = (out_filter == FILTER_IDX_WIDTH'(NUM_FILTERS - 1));
	assign out_data = scale_relu(sums[out_filter]);

	// Lane sums are frozen here so the lanes can start the next patch.
	always_ff @(posedge clk) begin
		if (patch_done) begin
			sums <= acc;
		end
	end

	// ====================================================================
	// Output handshake FSM
	// ====================================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= EMPTY;
			drain_free <= 1'b1;
			out_req <= 1'b0;
			out_filter <= '0;
		end else begin
			case (state)
				EMPTY: begin
					if (patch_done) begin
						drain_free <= 1'b0;
						out_filter <= '0;
						state <= SEND_REQ;
					end
				end
				SEND_REQ: begin
					if (!out_req) begin
						out_req <= 1'b1;       // Data already settled.
					end else if (out_ack) begin
						out_req <= 1'b0;
						state <= WAIT_ACK_LOW;
					end
				end
				WAIT_ACK_LOW: begin
					if (!out_ack) begin
						if (last_filter) begin
							drain_free <= 1'b1;
							state <= EMPTY;
						end else begin
							out_filter <= out_filter + 1'b1;
							state <= SEND_REQ;
						end
					end
				end
				default: state <= EMPTY;
			endcase
		end
	end

	req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
		$rose(out_req) |-> !$past(out_ack));

	// The loader must hold a finished patch while results are pending.
	no_overwrite: assert property (@(posedge clk) disable iff (reset)
		patch_done |-> drain_free);

endmodule

//--- design/conv1_engine.sv
`timescale 1ns/1ps

module conv1_engine (
	input  logic                                          clk,
	input  logic                                          reset,
	input  logic                                          in_req,
	input  logic signed [conv1_pkg::DATA_WIDTH-1:0]       in_data,
	output logic                                          in_ack,
	output logic                                          out_req,
	output logic signed [conv1_pkg::DATA_WIDTH-1:0]       out_data,
	output logic        [conv1_pkg::FILTER_IDX_WIDTH-1:0] out_filter,
	input  logic                                          out_ack
);

	import conv1_pkg::*;

	logic mac_en;
	logic first;
	logic signed [DATA_WIDTH-1:0] act;
	logic [ADDR_WIDTH-1:0] addr;
	logic patch_done;
	logic drain_free;
	logic signed [DATA_WIDTH-1:0] weights [NUM_FILTERS];
	logic signed [ACC_WIDTH-1:0] acc [NUM_FILTERS];

	// ====================================================================
	// Input side
	// ====================================================================
	patch_loader u_loader (
		.clk        (clk),
		.reset      (reset),
		.in_req     (in_req),
		.in_data    (in_data),
		.in_ack     (in_ack),
		.drain_free (drain_free),
		.mac_en     (mac_en),
		.first      (first),
		.act        (act),
		.addr       (addr),
		.patch_done (patch_done)
	);

	conv1_weight_rom u_rom (
		.addr    (addr),
		.weights (weights)
	);

	// One lane per filter, all fed the same activation.
	for (genvar g = 0; g < NUM_FILTERS; g++) begin : g_lane
		mac_lane u_lane (
			.clk    (clk),
			.reset  (reset),
			.mac_en (mac_en),
			.first  (first),
			.act    (act),
			.weight (weights[g]),
			.acc    (acc[g])
		);
	end

	// ====================================================================
	// Output side
	// ====================================================================
	result_drain u_drain (
		.clk        (clk),
		.reset      (reset),
		.patch_done (patch_done),
		.acc        (acc),
		.drain_free (drain_free),
		.out_req    (out_req),
		.out_data   (out_data),
		.out_filter (out_filter),
		.out_ack    (out_ack)
	);

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;                             // 10 ns period.
		end
	end

	// Reset spans the first three rising edges.
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

//--- tests/conv1_tb.sv
`timescale 1ns/1ps

module conv1_tb;

	import conv1_pkg::*;

	localparam int TIMEOUT = 200;
	localparam int NUM_RANDOM = 20;
	localparam int SLOW_ACK = 120;                     // Held ack for the back-pressure case.

	logic clk;
	logic reset;
	logic in_req;
	logic signed [DATA_WIDTH-1:0] in_data;
	logic in_ack;
	logic out_req;
	logic signed [DATA_WIDTH-1:0] out_data;
	logic [FILTER_IDX_WIDTH-1:0] out_filter;
	logic out_ack;

	logic [NUM_FILTERS*DATA_WIDTH-1:0] wmem [2**ADDR_WIDTH];
	logic signed [DATA_WIDTH-1:0] patch [PATCH_LEN];
	int expected [$];
	int patches_sent;
	int results_taken;
	int stall_cycles;
	int last_stall;
	bit slow_last;
	logic prev_in_req;
	logic prev_in_ack;
	logic prev_out_req;
	logic prev_out_ack;

	clock_gen u_clock (
		.clk   (clk),
		.reset (reset)
	);

	conv1_engine dut (
		.clk        (clk),
		.reset      (reset),
		.in_req     (in_req),
		.in_data    (in_data),
		.in_ack     (in_ack),
		.out_req    (out_req),
		.out_data   (out_data),
		.out_filter (out_filter),
		.out_ack    (out_ack)
	);

	task automatic stop_with_error(input string line);
		$display("Errors found");
		$display("%s", line);
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_value(input string name, input int exp, input int got);
		assert (exp == got) else
			stop_with_error($sformatf("Fail at %0t: %s expected %0d, actual %0d",
				$time, name, exp, got));
	endtask

	// ====================================================================
	// Reference model
	// ====================================================================
	function automatic longint weight_of(input int pos, input int f);
		logic signed [DATA_WIDTH-1:0] w;
		w = wmem[pos][f*DATA_WIDTH +: DATA_WIDTH];
		return longint'(w);
	endfunction

	function automatic int model_result(input int f);
		longint sum;
		longint scaled;
		sum = 0;
		for (int k = 0; k < PATCH_LEN; k++) begin
			sum += longint'(patch[k]) * weight_of(k, f);
		end
		scaled = sum >>> FRAC_BITS;                     // Arithmetic shift.
		if (scaled < 0) begin
			return 0;
		end
		if (scaled > 32767) begin
			return 32767;
		end
		return int'(scaled);
	endfunction

	// ====================================================================
	// Host side of the input port
	// ====================================================================
	task automatic wait_in_ack(input logic level);
		int n;
		n = 0;
		while (in_ack !== level) begin
			@(posedge clk);
			#1;
			n++;
			if (n > TIMEOUT) begin
				stop_with_error($sformatf("Timeout waiting for in_ack to become %0b", level));
			end
		end
		stall_cycles = n;
	endtask

	task automatic wait_out_req_low();
		int n;
		n = 0;
		while (out_req) begin
			@(posedge clk);
			#1;
			n++;
			if (n > TIMEOUT) begin
				stop_with_error("Timeout waiting for out_req to fall after out_ack");
			end
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (results_taken != NUM_FILTERS * patches_sent || out_req) begin
			@(posedge clk);
			#1;
			n++;
			if (n > TIMEOUT) begin
				stop_with_error("Timeout waiting for the drain to return all results");
			end
		end
	endtask

	task automatic send_patch();
		int prior;
		prior = patches_sent;
		for (int f = 0; f < NUM_FILTERS; f++) begin
			expected.push_back(model_result(f));
		end
		for (int k = 0; k < PATCH_LEN; k++) begin
			in_data = patch[k];
			in_req = 1'b1;
			wait_in_ack(1'b1);
			if (k == PATCH_LEN - 1) begin
				last_stall = stall_cycles;
				// Previous patch must be fully drained before the last ack.
				check_value("results_taken", NUM_FILTERS * prior, results_taken);
			end
			in_req = 1'b0;
			wait_in_ack(1'b0);
		end
		patches_sent++;
	endtask

	task automatic fill_random_patch();
		logic [31:0] r;
		for (int k = 0; k < PATCH_LEN; k++) begin
			r = $urandom();
			patch[k] = {{4{r[11]}}, r[11:0]};             // 12-bit signed range.
		end
	endtask

	// Full-scale activations whose signs follow (or oppose) one filter's weights.
	task automatic fill_signed_patch(input int f, input bit positive);
		for (int k = 0; k < PATCH_LEN; k++) begin
			patch[k] = ((weight_of(k, f) < 0) == positive) ? -16'sd32767 : 16'sd32767;
		end
	endtask

	// ====================================================================
	// Host side of the output port
	// ====================================================================
	initial begin : responder
		int delay;
		int want;
		int next_filter;
		next_filter = 0;
		forever begin
			@(posedge clk);
			#1;
			if (out_req && !out_ack) begin
				assert (expected.size() > 0) else
					stop_with_error("A result appeared with no patch pending");
				want = expected.pop_front();
				check_value("out_filter", next_filter, int'(out_filter));
				check_value("out_data", want, int'(out_data));
				delay = $urandom_range(5);
				if (slow_last && next_filter == NUM_FILTERS - 1) begin
					delay = SLOW_ACK;
					slow_last = 1'b0;
				end
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				out_ack = 1'b1;
				wait_out_req_low();
				out_ack = 1'b0;
				results_taken++;
				next_filter = (next_filter + 1) % NUM_FILTERS;
			end
		end
	end

	// Four-phase rules on both ports, sampled away from the driving edge.
	always @(negedge clk) begin
		if (!reset) begin
			if (prev_in_ack && !in_ack) begin
				assert (!prev_in_req) else stop_with_error("in_ack fell before in_req fell");
			end
			if (!prev_in_ack && in_ack) begin
				assert (prev_in_req) else stop_with_error("in_ack rose while in_req was low");
			end
			if (prev_out_req && !out_req) begin
				assert (prev_out_ack) else stop_with_error("out_req fell before out_ack rose");
			end
			if (!prev_out_req && out_req) begin
				assert (!prev_out_ack) else
					stop_with_error("out_req rose while out_ack was high");
			end
		end
		prev_in_req <= in_req;
		prev_in_ack <= in_ack;
		prev_out_req <= out_req;
		prev_out_ack <= out_ack;
	end

	// ====================================================================
	// Test sequence
	// ====================================================================
	initial begin : main
		void'($urandom(32'h9bf0a21a));
		in_req = 1'b0;
		in_data = '0;
		out_ack = 1'b0;
		patches_sent = 0;
		results_taken = 0;
		slow_last = 1'b0;
		$readmemh("weights.mem", wmem);

		repeat (4) @(posedge clk);
		#1;
		repeat (5) begin                               // Quiet until the first request.
			check_value("in_ack", 0, int'(in_ack));
			check_value("out_req", 0, int'(out_req));
			@(posedge clk);
			#1;
		end

		for (int p = 0; p < NUM_RANDOM; p++) begin
			fill_random_patch();
			send_patch();
		end

		for (int f = 0; f < NUM_FILTERS; f += 3) begin
			fill_signed_patch(f, 1'b1);
			check_value("model saturation", 32767, model_result(f));
			send_patch();
			fill_signed_patch(f, 1'b0);
			check_value("model relu", 0, model_result(f));
			send_patch();
		end

		// Slow host on the output side stalls the next patch.
		wait_drained();
		slow_last = 1'b1;
		fill_random_patch();
		send_patch();
		fill_random_patch();
		send_patch();
		assert (last_stall > 40) else
			stop_with_error("Last input ack of the next patch was not held back by the drain");

		wait_drained();
		repeat (10) begin
			@(posedge clk);
			#1;
		end
		$display("No errors");
		$finish;
	end

endmodule

//--- weights.mem
// One row per kernel position 0..31, eight 16-bit words, filter 7 left, filter 0 right.
00a3ff5d0127fe88003cffb20211fde7
ff1900e4fe6a0155ffd00098ff4101c2
0072fef300b8ff6e0203fe2d0049ff8a
fe9c0131ffa700d6fee10164ff0b0087
01e9ff360058fe5200c1ff9301a4fe77
ff7d0024fed801190063fe4b00f5ffc6
0145ffa0016cfe3fff2800ddfe9a003e
fee6018fff51007b01b6ff0e0034fe61
0091fe0500caffbbfe73012affe90108
ff4c00adfe2b01d30017ff620186fecd
01fffe970081ff2e00e7fe14ff790153
fe300069ff840142fea500bf0026ff0d
00d9ff1701b0fe6d0055ff9efe4101e0
ff8f0138fe1600a0ff3301c800bdfeb4
0060feca00f1ff4801a9fe36ff580093
fec10104ff6b01e4fef900470172ff22
0115ff0a003ffe8d00ccfe5effa301b1
ff670197fe440029ff7a0111fe8300e2
01cdfeb00084ffd4fe2101790052ff3b
fe5a00f8ff1c01260075fea901eeff96
0038ff8101d7fe620148ffb7fe0800ab
ffa90157fe9200e9ff05006600c3fe49
0163fe1f0097ff3901bbfe7eff94002d
fe8b00b2ff27018affc10134fe500117
00f4ff6a0169fe040088ff4f01d9fe9f
ff3e01a2fe5f00c7fe0d019e0031ff71
0187fe2600eaff9b015efee4ff1400d1
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000
00000000000000000000000000000000

//--- list.f
conv1_pkg.sv
design/conv1_weight_rom.sv
design/patch_loader.sv
design/mac_lane.sv
design/result_drain.sv
design/conv1_engine.sv
tests/clock_gen.sv
tests/conv1_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the conv1 testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module conv1_tb -f list.f -o conv1_sim
if [ $? -ne 0 ]; then
	echo "FAIL: Verilator build failed"
	exit 1
fi

./obj_dir/conv1_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "FAIL: testbench reported errors"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "FAIL: simulation exited with status $status"
	exit 1
fi
if ! grep -q "No errors" "$LOG"; then
	echo "FAIL: simulation ended without a result"
	exit 1
fi

echo "PASS"
exit 0
